//--- all.f
+incdir+logic
logic/rv_isa_pkg.sv
logic/pipe_pkg.sv
logic/exec_stage.sv
logic/mem_res_ctrl.sv
logic/apb_data_ram.sv
logic/rooth_lsu_top.sv
verification/tb_rooth_lsu.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass/fail from the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -f all.f --top-module tb_rooth_lsu -o sim_tb

# The log decides the result, so a nonzero exit from the run is tolerated here
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation passed$" sim.log; then
    exit 0
fi
exit 1

//--- verification/tb_rooth_lsu.sv
`timescale 1ns/1ps
`include "rooth_params.svh"

module tb_rooth_lsu;
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    localparam int N_OPS      = 400;
    localparam int CLK_PERIOD = 4;
    // A store plus the longest issue gap stays under 12 cycles
    localparam int TIMEOUT_NS = N_OPS * 12 * CLK_PERIOD + 2000;
    // At most two ops are in flight once issue stops
    localparam int DRAIN_CYCLES = 64;

    logic        clk_i;
    logic        rst_i;
    logic        issue_valid_i;
    issue_t      issue_i;
    logic        issue_ready_o;
    logic        wb_valid_o;
    wb_t         wb_o;

    logic [31:0] lcg_state;
    mem_word_u   mirror [`RAM_WORDS];
    wb_t         exp_q [$];
    int          issue_cnt;
    int          wb_cnt;
    int          error_cnt;

    rooth_lsu_top u_rooth_lsu_top (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .issue_ready_o (issue_ready_o),
        .wb_valid_o    (wb_valid_o),
        .wb_o          (wb_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ------------------------------------------------------------------------
    // Random numbers
    // ------------------------------------------------------------------------
    // Upper half only, the low LCG bits repeat too quickly
    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    function automatic logic [31:0] rand_word();
        logic [15:0] hi;
        logic [15:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi, lo};
    endfunction

    function automatic issue_t gen_op();
        issue_t      op;
        logic [15:0] r;
        logic [31:0] addr;
        int          sel;
        op             = '0;
        op.rs1_data    = rand_word();
        op.rs2_data    = rand_word();
        op.csr_rd_data = rand_word();
        r      = next_rand();
        op.rd  = r[4:0];
        sel    = int'(r[15:8]);
        // Byte address inside the RAM, often in the low 16 words to get reuse
        r      = next_rand();
        addr   = r[0] ? {24'b0, r[8:1]} : {26'b0, r[6:1]};
        case (int'(r[15:14]))
            0: begin
                op.opcode   = INST_TYPE_IL;
                op.imm      = {28'b0, r[12:9]};
                op.rs1_data = addr - op.imm;
                case (sel % 5)
                    0:       op.funct3 = INST_LB;
                    1:       op.funct3 = INST_LH;
                    2:       op.funct3 = INST_LW;
                    3:       op.funct3 = INST_LBU;
                    default: op.funct3 = INST_LHU;
                endcase
            end
            1: begin
                op.opcode   = INST_TYPE_S;
                op.imm      = {28'b0, r[12:9]};
                op.rs1_data = addr - op.imm;
                case (sel % 3)
                    0:       op.funct3 = INST_SB;
                    1:       op.funct3 = INST_SH;
                    default: op.funct3 = INST_SW;
                endcase
            end
            2: begin
                op.opcode = INST_TYPE_I;
                op.imm    = {{20{r[11]}}, r[11:0]};
                case (sel % 4)
                    0:       op.funct3 = INST_ADDI;
                    1:       op.funct3 = INST_XORI;
                    2:       op.funct3 = INST_ORI;
                    default: op.funct3 = INST_ANDI;
                endcase
            end
            default: begin
                op.opcode = INST_TYPE_CSR;
                op.imm    = {27'b0, r[13:9]};
                case (sel % 4)
                    0:       op.funct3 = INST_CSRRW;
                    1:       op.funct3 = INST_CSRRS;
                    2:       op.funct3 = INST_CSRRC;
                    default: op.funct3 = INST_CSRRWI;
                endcase
            end
        endcase
        return op;
    endfunction

    // ------------------------------------------------------------------------
    // Reference model, updates the mirror memory in issue order
    // ------------------------------------------------------------------------
    task automatic predict_wb(input issue_t op, output wb_t want);
        logic [`CPU_WIDTH-1:0] addr;
        logic [`APB_AW-3:0]    idx;
        logic [1:0]            lane;
        mem_word_u             w;
        addr    = op.rs1_data + op.imm;
        idx     = addr[`APB_AW-1:2];
        lane    = addr[1:0];
        w       = mirror[idx];
        want    = '0;
        want.rd = op.rd;
        case (op.opcode)
            INST_TYPE_IL: begin
                want.reg_wr_en = 1'b1;
                case (op.funct3)
                    INST_LB:  want.reg_wr_data = {{(`CPU_WIDTH-8){w.b[lane][7]}}, w.b[lane]};
                    INST_LH:  want.reg_wr_data = {{(`CPU_WIDTH-16){w.h[lane[1]][15]}},
                                                  w.h[lane[1]]};
                    INST_LW:  want.reg_wr_data = w;
                    INST_LBU: want.reg_wr_data = {{(`CPU_WIDTH-8){1'b0}}, w.b[lane]};
                    default:  want.reg_wr_data = {{(`CPU_WIDTH-16){1'b0}}, w.h[lane[1]]};
                endcase
            end
            INST_TYPE_S: begin
                // Only the addressed lane changes
                case (op.funct3)
                    INST_SB: w.b[lane]    = op.rs2_data[7:0];
                    INST_SH: w.h[lane[1]] = op.rs2_data[15:0];
                    default: w            = op.rs2_data;
                endcase
                mirror[idx] = w;
            end
            INST_TYPE_I: begin
                want.reg_wr_en = 1'b1;
                case (op.funct3)
                    INST_ADDI: want.reg_wr_data = op.rs1_data + op.imm;
                    INST_XORI: want.reg_wr_data = op.rs1_data ^ op.imm;
                    INST_ORI:  want.reg_wr_data = op.rs1_data | op.imm;
                    default:   want.reg_wr_data = op.rs1_data & op.imm;
                endcase
            end
            default: begin
                want.reg_wr_en   = 1'b1;
                want.reg_wr_data = op.csr_rd_data;
                want.csr_wr_en   = 1'b1;
                case (op.funct3)
                    INST_CSRRW: want.csr_wr_data = op.rs1_data;
                    INST_CSRRS: want.csr_wr_data = op.csr_rd_data | op.rs1_data;
                    INST_CSRRC: want.csr_wr_data = op.csr_rd_data & ~op.rs1_data;
                    default:    want.csr_wr_data = op.imm;
                endcase
            end
        endcase
    endtask

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    task automatic stop_on_error();
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_wb(input wb_t got, input wb_t want);
        if (got.rd !== want.rd) begin
            $display("ERROR: wb_o.rd got %h expected %h (wb %0d)", got.rd, want.rd, wb_cnt);
            error_cnt++;
        end else if (got.reg_wr_en !== want.reg_wr_en) begin
            $display("ERROR: wb_o.reg_wr_en got %h expected %h (wb %0d)",
                     got.reg_wr_en, want.reg_wr_en, wb_cnt);
            error_cnt++;
        end else if (got.reg_wr_data !== want.reg_wr_data) begin
            $display("ERROR: wb_o.reg_wr_data got %h expected %h (wb %0d)",
                     got.reg_wr_data, want.reg_wr_data, wb_cnt);
            error_cnt++;
        end else if (got.csr_wr_en !== want.csr_wr_en) begin
            $display("ERROR: wb_o.csr_wr_en got %h expected %h (wb %0d)",
                     got.csr_wr_en, want.csr_wr_en, wb_cnt);
            error_cnt++;
        end else if (got.csr_wr_data !== want.csr_wr_data) begin
            $display("ERROR: wb_o.csr_wr_data got %h expected %h (wb %0d)",
                     got.csr_wr_data, want.csr_wr_data, wb_cnt);
            error_cnt++;
        end
        if (error_cnt != 0) stop_on_error();
    endtask

    task automatic check_count(input int issued, input int retired);
        if (retired != issued) begin
            $display("ERROR: writeback count got %h expected %h", retired, issued);
            error_cnt++;
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("ERROR: %s got %h expected %h", name, got, want);
            error_cnt++;
            stop_on_error();
        end
    endtask

    // ------------------------------------------------------------------------
    // Writeback monitor, one pop per pulse
    // ------------------------------------------------------------------------
    initial begin
        wb_t want;
        forever begin
            @(negedge clk_i);
            if (!rst_i && wb_valid_o) begin
                if (exp_q.size() == 0) begin
                    $display("A writeback pulse arrived with no instruction outstanding");
                    error_cnt++;
                    stop_on_error();
                end else begin
                    want = exp_q.pop_front();
                    check_wb(wb_o, want);
                    wb_cnt++;
                end
            end
        end
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("The run timed out with %0d writebacks still outstanding", exp_q.size());
        error_cnt++;
        stop_on_error();
    end

    // ------------------------------------------------------------------------
    // Reset and stimulus
    // ------------------------------------------------------------------------
    initial begin
        issue_t op;
        wb_t    want;
        int     gap;
        int     drain;
        logic   accepted;
        rst_i         = 1'b1;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        lcg_state     = 32'd98545;
        issue_cnt     = 0;
        wb_cnt        = 0;
        error_cnt     = 0;
        for (int i = 0; i < `RAM_WORDS; i++) begin
            mirror[i] = '0;
        end

        // Four reset edges, the last check lands just after release
        for (int i = 0; i < 4; i++) begin
            @(posedge clk_i);
            if (i == 3) rst_i <= 1'b0;
            @(negedge clk_i);
            check_flag("wb_valid_o", wb_valid_o, 1'b0);
            check_flag("issue_ready_o", issue_ready_o, 1'b1);
        end
        @(posedge clk_i);

        for (int n = 0; n < N_OPS; n++) begin
            gap = int'(next_rand() % 16'd4);
            op  = gen_op();
            if (gap != 0) begin
                issue_valid_i <= 1'b0;
                repeat (gap) @(posedge clk_i);
            end
            issue_valid_i <= 1'b1;
            issue_i       <= op;
            accepted = 1'b0;
            // Valid and data hold until the DUT is ready
            while (!accepted) begin
                @(negedge clk_i);
                if (issue_ready_o) begin
                    accepted = 1'b1;
                    predict_wb(op, want);
                    exp_q.push_back(want);
                    issue_cnt++;
                end
                @(posedge clk_i);
            end
        end
        issue_valid_i <= 1'b0;

        // Bounded wait for the last writebacks
        drain = 0;
        while (exp_q.size() != 0 && drain < DRAIN_CYCLES) begin
            @(negedge clk_i);
            drain++;
        end
        // Room for any stray pulse to show up
        repeat (16) @(negedge clk_i);
        check_count(issue_cnt, wb_cnt);

        if (error_cnt == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            stop_on_error();
        end
    end

endmodule

//--- logic/rooth_lsu_top.sv
`timescale 1ns/1ps
`include "rooth_params.svh"

module rooth_lsu_top (
    input  logic             clk_i,
    input  logic             rst_i,

    input  logic             issue_valid_i,
    input  pipe_pkg::issue_t issue_i,
    output logic             issue_ready_o,

    output logic             wb_valid_o,
    output pipe_pkg::wb_t    wb_o
);
    import pipe_pkg::*;

    // Stage link
    logic                  ex_valid;
    logic                  ex_ready;
    exec_t                 ex_data;

    // APB
    logic [`APB_AW-1:0]    paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [`CPU_WIDTH-1:0] pwdata;
    logic [`CPU_WIDTH-1:0] prdata;
    logic                  pready;

    exec_stage u_exec_stage (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .issue_ready_o (issue_ready_o),
        .ex_ready_i    (ex_ready),
        .ex_valid_o    (ex_valid),
        .ex_o          (ex_data)
    );

    mem_res_ctrl u_mem_res_ctrl (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .ex_valid_i (ex_valid),
        .ex_i       (ex_data),
        .ex_ready_o (ex_ready),
        .paddr_o    (paddr),
        .psel_o     (psel),
        .penable_o  (penable),
        .pwrite_o   (pwrite),
        .pwdata_o   (pwdata),
        .prdata_i   (prdata),
        .pready_i   (pready),
        .wb_valid_o (wb_valid_o),
        .wb_o       (wb_o)
    );

    apb_data_ram u_apb_data_ram (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .paddr_i   (paddr),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready)
    );

endmodule

//--- logic/apb_data_ram.sv
`timescale 1ns/1ps
`include "rooth_params.svh"

module apb_data_ram (
    input  logic                  clk_i,
    input  logic                  rst_i,

    input  logic [`APB_AW-1:0]    paddr_i,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic [`CPU_WIDTH-1:0] pwdata_i,
    output logic [`CPU_WIDTH-1:0] prdata_o,
    output logic                  pready_o
);
    localparam int IDX_W = `APB_AW - 2;

    logic [`CPU_WIDTH-1:0] mem [`RAM_WORDS];
    logic [IDX_W-1:0]      word_idx;
    logic                  setup;
    logic                  access;

    // Byte address, word index sits above bit 1
    assign word_idx = paddr_i[`APB_AW-1:2];
    assign setup    = psel_i && !penable_i;
    assign access   = psel_i && penable_i;

    // No wait states, ready in the first ACCESS cycle
    assign pready_o = access;

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `RAM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (access && pwrite_i) begin
            mem[word_idx] <= pwdata_i;
        end
    end

    // Read sampled at SETUP so the data is there during ACCESS
    always_ff @(posedge clk_i) begin
        if (setup && !pwrite_i) begin
            prdata_o <= mem[word_idx];
        end
    end

endmodule

//--- logic/mem_res_ctrl.sv
`timescale 1ns/1ps
`include "rooth_params.svh"

module mem_res_ctrl (
    input  logic                   clk_i,
    input  logic                   rst_i,

    input  logic                   ex_valid_i,
    input  pipe_pkg::exec_t        ex_i,
    output logic                   ex_ready_o,

    // APB master
    output logic [`APB_AW-1:0]     paddr_o,
    output logic                   psel_o,
    output logic                   penable_o,
    output logic                   pwrite_o,
    output logic [`CPU_WIDTH-1:0]  pwdata_o,
    input  logic [`CPU_WIDTH-1:0]  prdata_i,
    input  logic                   pready_i,

    output logic                   wb_valid_o,
    output pipe_pkg::wb_t          wb_o
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        RD_SETUP,
        RD_ACCESS,
        WR_SETUP,
        WR_ACCESS,
        DONE
    } state_e;

    state_e                state_q;
    state_e                state_d;
    exec_t                 op_q;
    exec_t                 op_cur;
    wb_t                   wb_q;
    wb_t                   wb_d;
    logic [`CPU_WIDTH-1:0] wdata_q;
    mem_word_u             rd_word;
    mem_word_u             merge_word;
    logic [1:0]            lane_sel;
    logic [7:0]            byte_lane;
    logic [15:0]           half_lane;
    logic                  ex_take;
    logic                  rd_done;

    assign ex_ready_o = (state_q == IDLE) || (state_q == DONE);
    assign ex_take    = ex_valid_i && ex_ready_o;
    assign rd_done    = (state_q == RD_ACCESS) && pready_i;

    // Newly taken op resolves at once, memory ops resolve from the held copy
    assign op_cur    = ex_take ? ex_i : op_q;
    assign rd_word   = prdata_i;
    assign lane_sel  = op_cur.alu_res[1:0];
    assign byte_lane = rd_word.b[lane_sel];
    assign half_lane = rd_word.h[lane_sel[1]];

    // ------------------------------------------------------------------------
    // Result routing, load extraction and store merge
    // ------------------------------------------------------------------------
    always_comb begin
        wb_d       = '0;
        wb_d.rd    = op_cur.op.rd;
        merge_word = rd_word;
        case (op_cur.route)
            RESCTRL_MEM: begin
                case (op_cur.op.funct3)
                    INST_SB: merge_word.b[lane_sel]    = op_cur.op.rs2_data[7:0];
                    INST_SH: merge_word.h[lane_sel[1]] = op_cur.op.rs2_data[15:0];
                    INST_SW: merge_word                = op_cur.op.rs2_data;
                    default: merge_word                = rd_word;
                endcase
            end
            RESCTRL_CSR: begin
                wb_d.reg_wr_en   = 1'b1;
                wb_d.reg_wr_data = op_cur.op.csr_rd_data;
                wb_d.csr_wr_en   = 1'b1;
                case (op_cur.op.funct3)
                    INST_CSRRW:  wb_d.csr_wr_data = op_cur.op.rs1_data;
                    INST_CSRRWI: wb_d.csr_wr_data = op_cur.op.imm;
                    default:     wb_d.csr_wr_data = op_cur.alu_res;
                endcase
            end
            default: begin
                wb_d.reg_wr_en = 1'b1;
                if (op_cur.op.opcode == INST_TYPE_IL) begin
                    case (op_cur.op.funct3)
                        INST_LB:  wb_d.reg_wr_data = {{(`CPU_WIDTH-8){byte_lane[7]}}, byte_lane};
                        INST_LH:  wb_d.reg_wr_data = {{(`CPU_WIDTH-16){half_lane[15]}}, half_lane};
                        INST_LW:  wb_d.reg_wr_data = rd_word;
                        INST_LBU: wb_d.reg_wr_data = {{(`CPU_WIDTH-8){1'b0}}, byte_lane};
                        INST_LHU: wb_d.reg_wr_data = {{(`CPU_WIDTH-16){1'b0}}, half_lane};
                        default:  wb_d.reg_wr_data = '0;
                    endcase
                end else begin
                    wb_d.reg_wr_data = op_cur.alu_res;
                end
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // Control FSM
    // ------------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE, DONE: begin
                if (!ex_valid_i) begin
                    state_d = IDLE;
                end else if (ex_i.route == RESCTRL_MEM || ex_i.op.opcode == INST_TYPE_IL) begin
                    state_d = RD_SETUP;
                end else begin
                    state_d = DONE;
                end
            end
            RD_SETUP: state_d = RD_ACCESS;
            RD_ACCESS: begin
                // Stores go on to write back the merged word
                if (pready_i) begin
                    state_d = (op_q.route == RESCTRL_MEM) ? WR_SETUP : DONE;
                end
            end
            WR_SETUP: state_d = WR_ACCESS;
            WR_ACCESS: begin
                if (pready_i) begin
                    state_d = DONE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ex_take) begin
            op_q <= ex_i;
        end
        if (ex_take || rd_done) begin
            wb_q <= wb_d;
        end
        if (rd_done) begin
            wdata_q <= merge_word;
        end
    end

    // APB drive, word aligned address
    assign paddr_o   = {op_q.alu_res[`APB_AW-1:2], 2'b00};
    assign psel_o    = (state_q == RD_SETUP) || (state_q == RD_ACCESS) ||
                       (state_q == WR_SETUP) || (state_q == WR_ACCESS);
    assign penable_o = (state_q == RD_ACCESS) || (state_q == WR_ACCESS);
    assign pwrite_o  = (state_q == WR_SETUP) || (state_q == WR_ACCESS);
    assign pwdata_o  = wdata_q;

    assign wb_valid_o = (state_q == DONE);
    assign wb_o       = wb_q;

endmodule

//--- logic/exec_stage.sv
`timescale 1ns/1ps
`include "rooth_params.svh"

module exec_stage (
    input  logic             clk_i,
    input  logic             rst_i,

    input  logic             issue_valid_i,
    input  pipe_pkg::issue_t issue_i,
    output logic             issue_ready_o,

    input  logic             ex_ready_i,
    output logic             ex_valid_o,
    output pipe_pkg::exec_t  ex_o
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    exec_t ex_d;

    // Slot is free when empty or drained this cycle
    assign issue_ready_o = !ex_valid_o || ex_ready_i;

    // ------------------------------------------------------------------------
    // ALU and route decode
    // ------------------------------------------------------------------------
    always_comb begin
        ex_d         = '0;
        ex_d.op      = issue_i;
        ex_d.route   = RESCTRL_REG;
        ex_d.alu_res = '0;
        case (issue_i.opcode)
            INST_TYPE_IL: begin
                ex_d.alu_res = issue_i.rs1_data + issue_i.imm;
            end
            INST_TYPE_S: begin
                ex_d.alu_res = issue_i.rs1_data + issue_i.imm;
                ex_d.route   = RESCTRL_MEM;
            end
            INST_TYPE_I: begin
                case (issue_i.funct3)
                    INST_ADDI: ex_d.alu_res = issue_i.rs1_data + issue_i.imm;
                    INST_XORI: ex_d.alu_res = issue_i.rs1_data ^ issue_i.imm;
                    INST_ORI:  ex_d.alu_res = issue_i.rs1_data | issue_i.imm;
                    INST_ANDI: ex_d.alu_res = issue_i.rs1_data & issue_i.imm;
                    default:   ex_d.alu_res = '0;
                endcase
            end
            INST_TYPE_CSR: begin
                ex_d.route = RESCTRL_CSR;
                // Set and clear only, write forms are resolved downstream
                case (issue_i.funct3)
                    INST_CSRRS: ex_d.alu_res = issue_i.csr_rd_data | issue_i.rs1_data;
                    INST_CSRRC: ex_d.alu_res = issue_i.csr_rd_data & ~issue_i.rs1_data;
                    default:    ex_d.alu_res = '0;
                endcase
            end
            default: begin
                ex_d.alu_res = '0;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // Pipeline slot
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ex_valid_o <= 1'b0;
        end else if (issue_ready_o) begin
            ex_valid_o <= issue_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_valid_i && issue_ready_o) begin
            ex_o <= ex_d;
        end
    end

endmodule

//--- logic/pipe_pkg.sv
`include "rooth_params.svh"

package pipe_pkg;

    // ------------------------------------------------------------------------
    // Issue port payload, a fully decoded micro-op
    // ------------------------------------------------------------------------
    typedef struct packed {
        rv_isa_pkg::opcode_e   opcode;
        rv_isa_pkg::funct3_t   funct3;
        logic [4:0]            rd;
        logic [`CPU_WIDTH-1:0] rs1_data;
        logic [`CPU_WIDTH-1:0] rs2_data;
        logic [`CPU_WIDTH-1:0] imm;
        // Old CSR value, read by the decoder
        logic [`CPU_WIDTH-1:0] csr_rd_data;
    } issue_t;

    // ------------------------------------------------------------------------
    // Execute to result-control link
    // ------------------------------------------------------------------------
    typedef struct packed {
        issue_t                 op;
        // Address, arithmetic value or CSR set/clear value
        logic [`CPU_WIDTH-1:0]  alu_res;
        rv_isa_pkg::res_route_e route;
    } exec_t;

    // ------------------------------------------------------------------------
    // Writeback port
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [4:0]            rd;
        logic                  reg_wr_en;
        logic [`CPU_WIDTH-1:0] reg_wr_data;
        logic                  csr_wr_en;
        logic [`CPU_WIDTH-1:0] csr_wr_data;
    } wb_t;

endpackage

//--- logic/rv_isa_pkg.sv
`include "rooth_params.svh"

package rv_isa_pkg;

    // ------------------------------------------------------------------------
    // Opcodes handled by the load/store and result-routing path
    // ------------------------------------------------------------------------
    typedef enum logic [6:0] {
        INST_TYPE_IL  = 7'b0000011,
        INST_TYPE_S   = 7'b0100011,
        INST_TYPE_I   = 7'b0010011,
        INST_TYPE_CSR = 7'b1110011
    } opcode_e;

    typedef logic [2:0] funct3_t;

    // Loads
    localparam funct3_t INST_LB     = 3'b000;
    localparam funct3_t INST_LH     = 3'b001;
    localparam funct3_t INST_LW     = 3'b010;
    localparam funct3_t INST_LBU    = 3'b100;
    localparam funct3_t INST_LHU    = 3'b101;

    // Stores
    localparam funct3_t INST_SB     = 3'b000;
    localparam funct3_t INST_SH     = 3'b001;
    localparam funct3_t INST_SW     = 3'b010;

    // Op-imm subset
    localparam funct3_t INST_ADDI   = 3'b000;
    localparam funct3_t INST_XORI   = 3'b100;
    localparam funct3_t INST_ORI    = 3'b110;
    localparam funct3_t INST_ANDI   = 3'b111;

    // CSR access
    localparam funct3_t INST_CSRRW  = 3'b001;
    localparam funct3_t INST_CSRRS  = 3'b010;
    localparam funct3_t INST_CSRRC  = 3'b011;
    localparam funct3_t INST_CSRRWI = 3'b101;

    // Where a result ends up
    typedef enum logic [1:0] {
        RESCTRL_REG = 2'd0,
        RESCTRL_MEM = 2'd1,
        RESCTRL_CSR = 2'd2
    } res_route_e;

    // One memory word, seen as byte lanes or as half lanes
    typedef union packed {
        logic [(`CPU_WIDTH/8)-1:0][7:0]   b;
        logic [(`CPU_WIDTH/16)-1:0][15:0] h;
    } mem_word_u;

endpackage

//--- logic/rooth_params.svh
`ifndef ROOTH_PARAMS_SVH
`define ROOTH_PARAMS_SVH

// ----------------------------------------------------------------------------
// Core word size
// ----------------------------------------------------------------------------

// Integer register and data memory word width
`define CPU_WIDTH 32

// ----------------------------------------------------------------------------
// Data memory geometry
// ----------------------------------------------------------------------------

// Words held by the APB data RAM
`define RAM_WORDS 64

// Byte address width on the APB side, 64 words of 4 bytes
`define APB_AW 8

`endif
